//--- sd_pkg.sv
// SD host byte interface
// strobe/data bundle sent to the host and the data byte type
`default_nettype none

package sd_pkg;

    localparam int BLOCK_BYTES = 512;

    typedef logic [7:0] sd_byte_t;

    // level strobes, each held until busy rises
    typedef struct packed {
        logic        rst;
        logic        r_block;
        logic        r_byte;
        logic        w_block;
        logic        w_byte;
        sd_byte_t    wdata;
        logic [31:0] block_addr;
    } sd_cmd_t;

endpackage

`default_nettype wire

//--- autotest_pkg.sv
// Self-test sequencer definitions
// test block layout, header and parameter types, FSM states, timeout
`default_nettype none

package autotest_pkg;

    localparam logic [31:0] SIGNATURE = 32'hAABBCCDD;
    localparam int N_BLOCK_BYTES = 2;
    // sig 0..3, iterations 4, n_blocks 5..6, sclk_speed 7, cmd18 8
    localparam int HDR_BYTES = 9;
    // 4-byte little-endian timing slot per iteration
    localparam int SLOT_BASE = 9;
    localparam int START_BLOCK = 16;
    localparam int TEST_TIMEOUT = 2000;

    typedef struct packed {
        logic [8*N_BLOCK_BYTES-1:0] n_blocks;
        logic [7:0]                 sclk_speed;
        logic [7:0]                 cmd18;
    } uut_params_t;

    typedef struct packed {
        logic [31:0] signature;
        logic [7:0]  iterations;
        uut_params_t params;
    } test_hdr_t;

    typedef logic [31:0] elapsed_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_SD_RST,
        ST_SD_RST_WAIT,
        ST_RD_BLOCK,
        ST_RD_BLOCK_WAIT,
        ST_RD_BYTE,
        ST_RD_BYTE_WAIT,
        ST_RD_STORE,
        ST_CHECK,
        ST_RUN,
        ST_W_BLOCK,
        ST_W_BLOCK_WAIT,
        ST_W_FETCH,
        ST_W_BYTE,
        ST_W_BYTE_WAIT,
        ST_NEXT,
        ST_HALT
    } seq_state_t;

endpackage

`default_nettype wire

//--- test_header_regs.sv
// Test header registers
// byte-wise capture of the block header, decoded view for the sequencer
// and the UUT, and the stored byte served back for write-back
`timescale 1ns/1ps
`default_nettype none

module test_header_regs
    import sd_pkg::*;
    import autotest_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       clear_i,
    input  wire logic       wr_i,
    input  wire logic [7:0] idx_i,
    input  wire sd_byte_t   din_i,
    output test_hdr_t       hdr_o,
    output sd_byte_t        rd_byte_o
);

    sd_byte_t   hdr_q [HDR_BYTES];
    logic [3:0] sel;
    logic       in_hdr;

    assign sel = idx_i[3:0];
    assign in_hdr = (idx_i < HDR_BYTES);

    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
        begin
            for (int i = 0; i < HDR_BYTES; i++)
                hdr_q[i] <= '0;
        end
        else if (wr_i && in_hdr)
        begin
            hdr_q[sel] <= din_i;
        end
    end

    // signature big-endian, n_blocks little-endian
    always_comb
    begin
        hdr_o.signature = {hdr_q[0], hdr_q[1], hdr_q[2], hdr_q[3]};
        hdr_o.iterations = hdr_q[4];
        for (int i = 0; i < N_BLOCK_BYTES; i++)
            hdr_o.params.n_blocks[8*i +: 8] = hdr_q[5 + i];
        hdr_o.params.sclk_speed = hdr_q[5 + N_BLOCK_BYTES];
        hdr_o.params.cmd18 = hdr_q[6 + N_BLOCK_BYTES];
    end

    // same layout as read, so the echo is byte for byte
    assign rd_byte_o = in_hdr ? hdr_q[sel] : '0;

endmodule

`default_nettype wire

//--- payload_buffer.sv
// Payload buffer
// one block of byte RAM, synchronous read, keeps the payload
// between the block read and its write-back
`timescale 1ns/1ps
`default_nettype none

module payload_buffer
    import sd_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       we_i,
    input  wire logic [8:0] addr_i,
    input  wire sd_byte_t   din_i,
    output sd_byte_t        dout_o
);

    sd_byte_t mem [BLOCK_BYTES];

    always_ff @(posedge clk)
    begin
        if (we_i)
            mem[addr_i] <= din_i;
        dout_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- autotest_seq.sv
// Self-test sequencer FSM
// reads a test block, checks its signature, runs and times the UUT,
// writes the block back with the elapsed time in the iteration slot
`timescale 1ns/1ps
`default_nettype none

module autotest_seq
    import sd_pkg::*;
    import autotest_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       sd_busy_i,
    input  wire sd_byte_t   sd_rdata_i,
    output sd_cmd_t         sd_cmd_o,
    input  wire logic       uut_finish_i,
    output logic            uut_rst_o,
    output logic            uut_mux_o,
    output logic            uut_start_o,
    output logic            halted_o,
    input  wire test_hdr_t  hdr_i,
    input  wire sd_byte_t   hdr_byte_i,
    input  wire sd_byte_t   buf_byte_i,
    output logic            hdr_clear_o,
    output logic            hdr_wr_o,
    output logic            buf_we_o,
    output logic [8:0]      idx_o,
    output sd_byte_t        byte_o
);

    seq_state_t  state;
    seq_state_t  next_state;
    logic [8:0]  byte_cnt;
    logic [7:0]  iter_cnt;
    logic [31:0] block_cnt;
    elapsed_t    timer;
    sd_byte_t    rd_byte_q;

    logic        byte_clr;
    logic        byte_inc;
    logic        iter_inc;
    logic        iter_clr;
    logic        block_inc;
    logic        timer_clr;
    logic        timer_en;
    logic        last_byte;
    logic        more_iter;

    logic [10:0] slot_ofs;
    logic [10:0] idx_ext;
    logic [10:0] lane_ofs;
    logic        slot_hit;
    sd_byte_t    wr_byte;

    assign last_byte = (byte_cnt == 9'(BLOCK_BYTES - 1));
    assign more_iter = ({1'b0, iter_cnt} + 9'd1) < {1'b0, hdr_i.iterations};
    assign timer_en = uut_start_o && !uut_finish_i && (timer < TEST_TIMEOUT);

    // write-back byte: header, current timing slot, else payload
    assign idx_ext = {2'b00, byte_cnt};
    assign slot_ofs = 11'(SLOT_BASE) + {1'b0, iter_cnt, 2'b00};
    assign lane_ofs = idx_ext - slot_ofs;
    assign slot_hit = (idx_ext >= slot_ofs) && (idx_ext < slot_ofs + 11'd4);

    always_comb
    begin
        if (byte_cnt < HDR_BYTES)
            wr_byte = hdr_byte_i;
        else if (slot_hit)
            wr_byte = timer[8*lane_ofs[1:0] +: 8];
        else
            wr_byte = buf_byte_i;
    end

    always_comb
    begin
        next_state = state;
        byte_clr = 1'b0;
        byte_inc = 1'b0;
        iter_inc = 1'b0;
        iter_clr = 1'b0;
        block_inc = 1'b0;
        timer_clr = 1'b0;
        sd_cmd_o = '0;
        sd_cmd_o.block_addr = 32'(START_BLOCK) + block_cnt;
        sd_cmd_o.wdata = wr_byte;

        case (state)
            ST_IDLE:
                next_state = ST_SD_RST;
            ST_SD_RST:
            begin
                sd_cmd_o.rst = 1'b1;
                if (sd_busy_i)
                    next_state = ST_SD_RST_WAIT;
            end
            ST_SD_RST_WAIT:
            begin
                if (!sd_busy_i)
                    next_state = ST_RD_BLOCK;
            end
            ST_RD_BLOCK:
            begin
                sd_cmd_o.r_block = 1'b1;
                if (sd_busy_i)
                    next_state = ST_RD_BLOCK_WAIT;
            end
            ST_RD_BLOCK_WAIT:
            begin
                sd_cmd_o.r_block = 1'b1;
                byte_clr = 1'b1;
                if (!sd_busy_i)
                    next_state = ST_RD_BYTE;
            end
            ST_RD_BYTE:
            begin
                sd_cmd_o.r_block = 1'b1;
                sd_cmd_o.r_byte = 1'b1;
                if (sd_busy_i)
                    next_state = ST_RD_BYTE_WAIT;
            end
            ST_RD_BYTE_WAIT:
            begin
                sd_cmd_o.r_block = 1'b1;
                if (!sd_busy_i)
                    next_state = ST_RD_STORE;
            end
            ST_RD_STORE:
            begin
                sd_cmd_o.r_block = 1'b1;
                if (last_byte)
                begin
                    byte_clr = 1'b1;
                    next_state = ST_CHECK;
                end
                else
                begin
                    byte_inc = 1'b1;
                    next_state = ST_RD_BYTE;
                end
            end
            ST_CHECK:
            begin
                timer_clr = 1'b1;
                if (hdr_i.signature == SIGNATURE)
                    next_state = ST_RUN;
                else
                    next_state = ST_HALT;
            end
            ST_RUN:
            begin
                if (uut_finish_i || timer >= TEST_TIMEOUT)
                    next_state = ST_W_BLOCK;
            end
            ST_W_BLOCK:
            begin
                sd_cmd_o.w_block = 1'b1;
                if (sd_busy_i)
                    next_state = ST_W_BLOCK_WAIT;
            end
            ST_W_BLOCK_WAIT:
            begin
                sd_cmd_o.w_block = 1'b1;
                byte_clr = 1'b1;
                if (!sd_busy_i)
                    next_state = ST_W_FETCH;
            end
            // buffer read latency
            ST_W_FETCH:
            begin
                sd_cmd_o.w_block = 1'b1;
                next_state = ST_W_BYTE;
            end
            ST_W_BYTE:
            begin
                sd_cmd_o.w_block = 1'b1;
                sd_cmd_o.w_byte = 1'b1;
                if (sd_busy_i)
                    next_state = ST_W_BYTE_WAIT;
            end
            ST_W_BYTE_WAIT:
            begin
                sd_cmd_o.w_block = 1'b1;
                if (!sd_busy_i)
                begin
                    if (last_byte)
                    begin
                        next_state = ST_NEXT;
                    end
                    else
                    begin
                        byte_inc = 1'b1;
                        next_state = ST_W_FETCH;
                    end
                end
            end
            // same block again until the iteration count is reached
            ST_NEXT:
            begin
                if (!sd_busy_i)
                begin
                    if (more_iter)
                    begin
                        iter_inc = 1'b1;
                    end
                    else
                    begin
                        iter_clr = 1'b1;
                        block_inc = 1'b1;
                    end
                    next_state = ST_RD_BLOCK;
                end
            end
            ST_HALT:
                next_state = ST_HALT;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            byte_cnt <= '0;
            iter_cnt <= '0;
            block_cnt <= '0;
            timer <= '0;
        end
        else
        begin
            state <= next_state;
            if (byte_clr)
                byte_cnt <= '0;
            else if (byte_inc)
                byte_cnt <= byte_cnt + 9'd1;
            if (iter_clr)
                iter_cnt <= '0;
            else if (iter_inc)
                iter_cnt <= iter_cnt + 8'd1;
            if (block_inc)
                block_cnt <= block_cnt + 32'd1;
            if (timer_clr)
                timer <= '0;
            else if (timer_en)
                timer <= timer + 32'd1;
        end
    end

    // byte is valid as busy falls
    always_ff @(posedge clk)
    begin
        if (state == ST_RD_BYTE_WAIT && !sd_busy_i)
            rd_byte_q <= sd_rdata_i;
    end

    assign idx_o = byte_cnt;
    assign byte_o = rd_byte_q;
    assign hdr_clear_o = (state == ST_RD_BLOCK);
    assign hdr_wr_o = (state == ST_RD_STORE) && (byte_cnt < HDR_BYTES);
    assign buf_we_o = (state == ST_RD_STORE) && (byte_cnt >= HDR_BYTES);

    assign uut_start_o = (state == ST_RUN);
    assign uut_mux_o = (state == ST_CHECK) || (state == ST_RUN);
    assign uut_rst_o = (state != ST_RUN);
    assign halted_o = (state == ST_HALT);

endmodule

`default_nettype wire

//--- autotest_top.sv
// SD-driven self-test top level
// sequencer with its header registers and payload buffer
`timescale 1ns/1ps
`default_nettype none

module autotest_top
    import sd_pkg::*;
    import autotest_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    output sd_cmd_t        sd_cmd_o,
    input  wire logic      sd_busy_i,
    input  wire sd_byte_t  sd_rdata_i,
    output logic           uut_rst_o,
    output logic           uut_mux_o,
    output logic           uut_start_o,
    output uut_params_t    uut_params_o,
    input  wire logic      uut_finish_i,
    output logic           halted_o
);

    test_hdr_t  hdr;
    sd_byte_t   hdr_byte;
    sd_byte_t   buf_byte;
    sd_byte_t   rd_byte;
    logic       hdr_clear;
    logic       hdr_wr;
    logic       buf_we;
    logic [8:0] idx;

    autotest_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .sd_busy_i    (sd_busy_i),
        .sd_rdata_i   (sd_rdata_i),
        .sd_cmd_o     (sd_cmd_o),
        .uut_finish_i (uut_finish_i),
        .uut_rst_o    (uut_rst_o),
        .uut_mux_o    (uut_mux_o),
        .uut_start_o  (uut_start_o),
        .halted_o     (halted_o),
        .hdr_i        (hdr),
        .hdr_byte_i   (hdr_byte),
        .buf_byte_i   (buf_byte),
        .hdr_clear_o  (hdr_clear),
        .hdr_wr_o     (hdr_wr),
        .buf_we_o     (buf_we),
        .idx_o        (idx),
        .byte_o       (rd_byte)
    );

    // header index never exceeds 8 bits
    test_header_regs u_hdr (
        .clk       (clk),
        .rst       (rst),
        .clear_i   (hdr_clear),
        .wr_i      (hdr_wr),
        .idx_i     (idx[7:0]),
        .din_i     (rd_byte),
        .hdr_o     (hdr),
        .rd_byte_o (hdr_byte)
    );

    payload_buffer u_buf (
        .clk    (clk),
        .we_i   (buf_we),
        .addr_i (idx),
        .din_i  (rd_byte),
        .dout_o (buf_byte)
    );

    assign uut_params_o = hdr.params;

endmodule

`default_nettype wire

//--- autotest_tb.sv
// Self-test sequencer testbench
// SD card and UUT models around the top level, a table of test blocks,
// write-back checks per iteration and the final halt
`timescale 1ns/1ps
`default_nettype none

module autotest_tb
    import sd_pkg::*;
    import autotest_pkg::*;
;

    typedef struct packed {
        logic [31:0] sig;
        logic [7:0]  iterations;
        uut_params_t params;
        logic [31:0] delay;
        logic [7:0]  seed;
    } row_t;

    localparam int N_ROWS = 3;

    // two valid blocks then a bad signature
    // row 1 runs into the UUT timeout
    row_t rows [N_ROWS] = '{
        '{SIGNATURE, 8'd2, '{16'h0123, 8'h04, 8'h01}, 32'd37, 8'h5a},
        '{SIGNATURE, 8'd3, '{16'h0200, 8'h10, 8'h00}, 32'd2500, 8'hc3},
        '{32'hAABBCCDE, 8'd1, '{16'h0001, 8'h02, 8'h01}, 32'd10, 8'h11}
    };

    logic        clk;
    logic        rst;
    sd_cmd_t     sd_cmd;
    logic        sd_busy;
    sd_byte_t    sd_rdata;
    logic        uut_rst;
    logic        uut_mux;
    logic        uut_start;
    uut_params_t uut_params;
    logic        uut_finish;
    logic        halted;

    sd_byte_t    card [N_ROWS][BLOCK_BYTES];
    sd_byte_t    wr_buf [BLOCK_BYTES];
    int          writes_done [N_ROWS];
    int          cur_row;
    int          byte_idx;
    int          busy_cnt;
    int          run_cnt;
    logic        rd_open;
    logic        wr_open;
    sd_byte_t    rd_next;
    logic [31:0] lfsr;

    autotest_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .sd_cmd_o     (sd_cmd),
        .sd_busy_i    (sd_busy),
        .sd_rdata_i   (sd_rdata),
        .uut_rst_o    (uut_rst),
        .uut_mux_o    (uut_mux),
        .uut_start_o  (uut_start),
        .uut_params_o (uut_params),
        .uut_finish_i (uut_finish),
        .halted_o     (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input sd_byte_t got, input sd_byte_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_hdr(input string name, input test_hdr_t got, input test_hdr_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_elapsed(input string name, input elapsed_t got, input elapsed_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_params(input string name, input uut_params_t got,
                                input uut_params_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            report_fail();
        end
    endtask

    // outputs while the sequencer is held in reset
    task automatic check_reset_outputs();
        check_flag("strobes in reset", |{sd_cmd.rst, sd_cmd.r_block, sd_cmd.r_byte,
                                         sd_cmd.w_block, sd_cmd.w_byte}, 1'b0);
        check_flag("uut_start_o", uut_start, 1'b0);
        check_flag("uut_mux_o", uut_mux, 1'b0);
        check_flag("halted_o", halted, 1'b0);
        check_flag("uut_rst_o", uut_rst, 1'b1);
    endtask

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    // payload pattern over the full 9-bit offset
    function automatic sd_byte_t fill_byte(input sd_byte_t seed, input int i);
        return 8'(seed + i) ^ 8'(i >> 3);
    endfunction

    function automatic test_hdr_t row_hdr(input row_t r);
        test_hdr_t h;
        h.signature = r.sig;
        h.iterations = r.iterations;
        h.params = r.params;
        return h;
    endfunction

    // busy for 1 to 4 cycles with one LFSR step per bit
    task automatic start_busy();
        logic [1:0] n;
        lfsr = lfsr_step(lfsr);
        n[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        n[1] = lfsr[0];
        busy_cnt = 1 + int'(n);
        sd_busy <= 1'b1;
    endtask

    task automatic finish_write();
        test_hdr_t got_hdr;
        elapsed_t  got_slot;
        elapsed_t  exp_slot;
        int        slot;
        slot = SLOT_BASE + 4 * writes_done[cur_row];
        if (byte_idx != BLOCK_BYTES)
        begin
            $display("block write ended after %0d bytes instead of %0d", byte_idx, BLOCK_BYTES);
            report_fail();
        end
        got_hdr.signature = {wr_buf[0], wr_buf[1], wr_buf[2], wr_buf[3]};
        got_hdr.iterations = wr_buf[4];
        got_hdr.params.n_blocks = {wr_buf[6], wr_buf[5]};
        got_hdr.params.sclk_speed = wr_buf[7];
        got_hdr.params.cmd18 = wr_buf[8];
        check_hdr("written header", got_hdr, row_hdr(rows[cur_row]));
        got_slot = {wr_buf[slot + 3], wr_buf[slot + 2], wr_buf[slot + 1], wr_buf[slot]};
        exp_slot = (rows[cur_row].delay > TEST_TIMEOUT) ? elapsed_t'(TEST_TIMEOUT)
                                                         : rows[cur_row].delay;
        check_elapsed($sformatf("slot %0d", writes_done[cur_row]), got_slot, exp_slot);
        for (int i = HDR_BYTES; i < BLOCK_BYTES; i++)
        begin
            if (i < slot || i >= slot + 4)
                check_byte($sformatf("payload[%0d]", i), wr_buf[i], card[cur_row][i]);
        end
        for (int i = 0; i < BLOCK_BYTES; i++)
            card[cur_row][i] = wr_buf[i];
        writes_done[cur_row]++;
        if (writes_done[cur_row] == int'(rows[cur_row].iterations))
            cur_row++;
    endtask

    task automatic open_block(input string name);
        check_addr(name, sd_cmd.block_addr, 32'(START_BLOCK + cur_row));
        if (cur_row >= N_ROWS)
        begin
            $display("block access past the end of the block table");
            report_fail();
        end
        byte_idx = 0;
        start_busy();
    endtask

    // SD card model
    always @(posedge clk)
    begin
        if (rst)
        begin
            sd_busy <= 1'b0;
            busy_cnt = 0;
            rd_open = 1'b0;
            wr_open = 1'b0;
        end
        else
        begin
            if (rd_open && !sd_cmd.r_block)
                rd_open = 1'b0;
            if (wr_open && !sd_cmd.w_block)
            begin
                wr_open = 1'b0;
                finish_write();
            end
            if (busy_cnt > 0)
            begin
                busy_cnt--;
                if (busy_cnt == 0)
                begin
                    sd_busy <= 1'b0;
                    sd_rdata <= rd_next;
                end
            end
            else if (sd_cmd.rst)
            begin
                start_busy();
            end
            else if (sd_cmd.r_block && !rd_open)
            begin
                rd_open = 1'b1;
                open_block("read block_addr");
            end
            else if (sd_cmd.w_block && !wr_open)
            begin
                wr_open = 1'b1;
                open_block("write block_addr");
            end
            else if (sd_cmd.r_byte || sd_cmd.w_byte)
            begin
                if (byte_idx >= BLOCK_BYTES)
                begin
                    $display("byte strobe past the end of the block");
                    report_fail();
                end
                if (sd_cmd.r_byte)
                    rd_next = card[cur_row][byte_idx];
                else
                    wr_buf[byte_idx] = sd_cmd.wdata;
                byte_idx++;
                start_busy();
            end
        end
    end

    // UUT model
    always @(posedge clk)
    begin
        if (rst || uut_rst)
        begin
            uut_finish <= 1'b0;
            run_cnt = 0;
        end
        else if (uut_start && !uut_finish && cur_row < N_ROWS)
        begin
            check_params("uut_params_o", uut_params, rows[cur_row].params);
            check_flag("uut_mux_o", uut_mux, 1'b1);
            run_cnt++;
            if (run_cnt == int'(rows[cur_row].delay))
                uut_finish <= 1'b1;
        end
    end

    initial
    begin
        int limit;
        limit = 0;
        for (int r = 0; r < N_ROWS; r++)
            limit += 4000 + int'(rows[r].iterations) * (TEST_TIMEOUT + 16 * BLOCK_BYTES);
        repeat (limit) @(posedge clk);
        $display("watchdog: sequencer did not halt within %0d cycles", limit);
        report_fail();
    end

    initial
    begin
        rst = 1'b1;
        sd_busy = 1'b0;
        sd_rdata = '0;
        uut_finish = 1'b0;
        lfsr = 32'hfe17;
        cur_row = 0;
        for (int r = 0; r < N_ROWS; r++)
        begin
            writes_done[r] = 0;
            for (int i = HDR_BYTES; i < BLOCK_BYTES; i++)
                card[r][i] = fill_byte(rows[r].seed, i);
            card[r][0] = rows[r].sig[31:24];
            card[r][1] = rows[r].sig[23:16];
            card[r][2] = rows[r].sig[15:8];
            card[r][3] = rows[r].sig[7:0];
            card[r][4] = rows[r].iterations;
            card[r][5] = rows[r].params.n_blocks[7:0];
            card[r][6] = rows[r].params.n_blocks[15:8];
            card[r][7] = rows[r].params.sclk_speed;
            card[r][8] = rows[r].params.cmd18;
        end
        repeat (2) @(posedge clk);
        check_reset_outputs();
        rst <= 1'b0;

        while (halted !== 1'b1)
            @(posedge clk);

        // halt must come on the bad block with every valid block done
        check_addr("halted block_addr", sd_cmd.block_addr, 32'(START_BLOCK + N_ROWS - 1));
        for (int r = 0; r < N_ROWS; r++)
        begin
            if (rows[r].sig == SIGNATURE)
                check_count($sformatf("writes of row %0d", r), writes_done[r],
                            int'(rows[r].iterations));
            else
                check_count($sformatf("writes of row %0d", r), writes_done[r], 0);
        end

        repeat (40)
        begin
            @(posedge clk);
            check_flag("strobe after halt", |{sd_cmd.rst, sd_cmd.r_block, sd_cmd.r_byte,
                                               sd_cmd.w_block, sd_cmd.w_byte}, 1'b0);
            check_flag("halted_o", halted, 1'b1);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- autotest.f
sd_pkg.sv
autotest_pkg.sv
test_header_regs.sv
payload_buffer.sv
autotest_seq.sv
autotest_top.sv
autotest_tb.sv

//--- Makefile
SRCS := $(wildcard *.sv)

obj_dir/Vautotest_tb: autotest.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module autotest_tb -f autotest.f

run: obj_dir/Vautotest_tb
	./obj_dir/Vautotest_tb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
